/* common/a7800_consts.svh */
/*
 * Atari 7800 host glue constants
 * Cartridge header layout, backup RAM geometry and controller codes
 */
`ifndef A7800_CONSTS_SVH
`define A7800_CONSTS_SVH

// ======================================================================
// 7800 cartridge header
// ======================================================================
`define A78_HDR_BYTES       128
`define A78_OFS_SIG_FIRST   1    // "ATARI" starts here
`define A78_OFS_SIG_LAST    5
`define A78_OFS_FLAGS_HI    53
`define A78_OFS_FLAGS_LO    54
`define A78_OFS_JOY0        55
`define A78_OFS_JOY1        56
`define A78_OFS_REGION      57   // 0 NTSC, 1 PAL
`define A78_OFS_SAVE        58   // 0 none, 1 HSC, 2 SaveKey
`define A78_OFS_XM          63

// Backup RAM as SD sectors
`define BK_SECTORS          64

// Cart address space
`define CART_ADDR_W         25

// Header joystick code without second button sensing
`define JOY_TYPE_2600       5

`endif

/* common/cart_pkg.sv */
/*
 * Cartridge side types
 * Download kinds, captured 7800 header and cart memory writes
 */
`default_nettype none
`include "a7800_consts.svh"

package cart_pkg;

	// Decoded from the low six bits of the download index
	typedef enum logic [1:0] {
		DL_NONE    = 2'd0,
		DL_CART    = 2'd1,
		DL_BIOS    = 2'd2,
		DL_PALETTE = 2'd3
	} dl_kind_e;

	typedef struct packed {
		logic        is_7800;    // Signature matched
		logic [15:0] flags;
		logic [7:0]  joy0_type;
		logic [7:0]  joy1_type;
		logic [7:0]  region;
		logic [7:0]  save;
		logic [7:0]  xm;
	} cart_info_t;

	// One byte into cart memory, header already stripped
	typedef struct packed {
		logic [`CART_ADDR_W-1:0] addr;
		logic [7:0]              data;
	} mem_wr_t;

endpackage

`default_nettype wire

/* common/input_pkg.sv */
/*
 * Input side types
 * Player buttons, controller port types, console options and RIOT/TIA inputs
 */
`default_nettype none

package input_pkg;

	// All buttons active high
	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic fire_a;
		logic fire_b;
		logic select;
		logic pause;
		logic start;
	} pad_t;

	typedef enum logic [3:0] {
		PT_NONE       = 4'd0,
		PT_JOY7800    = 4'd1,
		PT_LIGHTGUN   = 4'd2,
		PT_TRAKBALL   = 4'd3,
		PT_JOY2600    = 4'd4,
		PT_DRIVING    = 4'd5,
		PT_KEYPAD     = 4'd6,
		PT_STMOUSE    = 4'd7,
		PT_AMIGAMOUSE = 4'd8,
		PT_SAVEKEY    = 4'd9
	} port_type_e;

	// OSD option word
	typedef struct packed {
		logic [1:0] ctrl1;       // 0 auto, 1 joystick, 2 paddle, 3 SaveKey
		logic [1:0] ctrl2;
		logic [1:0] region;      // 0 auto, 1 NTSC, 2 PAL
		logic [1:0] hscart;      // 0 auto, 1 on, 2 off
		logic       diff_right;
		logic       diff_left;
		logic       bw;
		logic       tia_mode;
		logic       bk_save;     // Rising edge writes backup RAM
	} options_t;

	typedef struct packed {
		logic [7:0] pa;          // {R L D U} P1, then P2
		logic [7:0] pb;
		logic [1:0] ilatch;      // Fire latches, P2 then P1
		logic [3:0] idump;
	} riot_in_t;

endpackage

`default_nettype wire

/* cart/cart_header_parser.sv */
/*
 * Cartridge download parser
 * Classifies the download, captures the 7800 header, tracks the cart
 * size and turns each cart byte into a memory write minus the header
 */
`timescale 1ns/1ps
`default_nettype none
`include "a7800_consts.svh"

module cart_header_parser import cart_pkg::*; (
	input  wire                    clk_sys,
	input  wire                    i_arst_n,
	input  wire                    i_ioctl_download,
	input  wire                    i_ioctl_wr,
	input  wire [7:0]              i_ioctl_index,
	input  wire [`CART_ADDR_W-1:0] i_ioctl_addr,
	input  wire [7:0]              i_ioctl_dout,
	output dl_kind_e               o_dl_kind,
	output cart_info_t             o_cart_info,
	output logic [31:0]            o_cart_size,
	output logic                   o_cart_wr,
	output mem_wr_t                o_cart_wdata
);

	localparam logic [39:0]             SIG_ATARI = "ATARI";
	localparam logic [`CART_ADDR_W-1:0] HDR_LEN   = `A78_HDR_BYTES;

	logic [39:0] sig_q;
	logic [15:0] flags_q;
	logic [7:0]  joy0_q, joy1_q, region_q, save_q, xm_q;
	logic        is_7800;
	logic [`CART_ADDR_W-1:0] wr_addr;

	wire tia_mode = |i_ioctl_index[7:6];      // 2600 image
	wire cart_dl  = (o_dl_kind == DL_CART);
	wire cart_byte = cart_dl & i_ioctl_wr;

	always_comb begin
		o_dl_kind = DL_NONE;
		if (i_ioctl_download) begin
			case (i_ioctl_index[5:0])
				6'd1:       o_dl_kind = DL_CART;
				6'd0, 6'd2: o_dl_kind = DL_BIOS;
				6'd3:       o_dl_kind = DL_PALETTE;
				default:    o_dl_kind = DL_NONE;
			endcase
		end
	end

	assign is_7800 = (sig_q == SIG_ATARI);

	// ==================================================================
	// Header capture
	// ==================================================================
	always_ff @(posedge clk_sys or negedge i_arst_n) begin
		if (!i_arst_n) begin
			sig_q    <= '0;
			flags_q  <= '0;
			joy0_q   <= 8'd1;
			joy1_q   <= 8'd1;
			region_q <= '0;
			save_q   <= '0;
			xm_q     <= '0;
		end else if (cart_dl && tia_mode) begin
			sig_q    <= '0;
			flags_q  <= '0;
			joy0_q   <= 8'd1;
			joy1_q   <= 8'd1;
			region_q <= '0;
			save_q   <= '0;
			xm_q     <= '0;
		end else if (cart_byte) begin
			// Signature bytes arrive in order, shift them in
			if (i_ioctl_addr >= `A78_OFS_SIG_FIRST && i_ioctl_addr <= `A78_OFS_SIG_LAST)
				sig_q <= {sig_q[31:0], i_ioctl_dout};
			case (i_ioctl_addr)
				`A78_OFS_FLAGS_HI: flags_q[15:8] <= i_ioctl_dout;
				`A78_OFS_FLAGS_LO: flags_q[7:0]  <= i_ioctl_dout;
				`A78_OFS_JOY0:     joy0_q        <= i_ioctl_dout;
				`A78_OFS_JOY1:     joy1_q        <= i_ioctl_dout;
				`A78_OFS_REGION:   region_q      <= i_ioctl_dout;
				`A78_OFS_SAVE:     save_q        <= i_ioctl_dout;
				`A78_OFS_XM:       xm_q          <= i_ioctl_dout;
				default: ;
			endcase
		end
	end

	always_comb begin
		o_cart_info.is_7800   = is_7800;
		o_cart_info.flags     = is_7800 ? flags_q : 16'd0;
		o_cart_info.joy0_type = is_7800 ? joy0_q : 8'd1;   // Plain joystick otherwise
		o_cart_info.joy1_type = is_7800 ? joy1_q : 8'd1;
		o_cart_info.region    = region_q;
		o_cart_info.save      = save_q;
		o_cart_info.xm        = is_7800 ? xm_q : 8'd0;
	end

	// ==================================================================
	// Size and write path
	// ==================================================================
	assign wr_addr = (is_7800 && i_ioctl_addr >= HDR_LEN) ? i_ioctl_addr - HDR_LEN
		: i_ioctl_addr;

	always_ff @(posedge clk_sys or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_cart_size <= '0;
			o_cart_wr   <= 1'b0;
		end else begin
			o_cart_wr <= cart_byte;
			if (cart_byte)
				o_cart_size <= 32'(i_ioctl_addr) + 32'd1
					- (is_7800 ? 32'(`A78_HDR_BYTES) : 32'd0);
		end
	end

	always_ff @(posedge clk_sys) begin
		if (cart_byte) begin
			o_cart_wdata.addr <= wr_addr;
			o_cart_wdata.data <= i_ioctl_dout;
		end
	end

endmodule

`default_nettype wire

/* ports/console_options.sv */
/*
 * Console option registers
 * Resolves controller port types, video region and high score cart
 */
`timescale 1ns/1ps
`default_nettype none
`include "a7800_consts.svh"

module console_options import cart_pkg::*, input_pkg::*; (
	input  wire             clk_sys,
	input  wire             i_arst_n,
	input  wire options_t   i_status,
	input  wire cart_info_t i_cart_info,
	input  wire             i_tia_en,
	input  wire             i_tia_pal,
	output port_type_e      o_porta_type,
	output port_type_e      o_portb_type,
	output logic            o_two_btn_a,
	output logic            o_two_btn_b,
	output logic            o_bw,
	output logic [1:0]      o_diff,     // {right, left}
	output logic            o_pal,
	output logic            o_hsc_en
);

	// Header joystick code to port type
	function automatic port_type_e joy_lookup(input logic [7:0] code);
		case (code)
			8'd0:       return PT_NONE;
			8'd1, 8'd5: return PT_JOY7800;
			8'd2:       return PT_LIGHTGUN;
			8'd4:       return PT_TRAKBALL;
			8'd6:       return PT_DRIVING;
			8'd7:       return PT_JOY2600;
			8'd8:       return PT_STMOUSE;
			8'd9:       return PT_AMIGAMOUSE;
			8'd10:      return PT_SAVEKEY;
			default:    return PT_JOY7800;   // Paddles included
		endcase
	endfunction

	function automatic port_type_e resolve(input logic [1:0] ovr, input logic [7:0] code);
		case (ovr)
			2'd0:    return joy_lookup(code);
			2'd3:    return PT_SAVEKEY;
			default: return PT_JOY7800;
		endcase
	endfunction

	port_type_e porta_d, portb_d;

	// Both ports use joy0_type
	assign porta_d = resolve(i_status.ctrl1, i_cart_info.joy0_type);
	assign portb_d = resolve(i_status.ctrl2, i_cart_info.joy0_type);

	wire use_sk = (porta_d == PT_SAVEKEY) || (portb_d == PT_SAVEKEY);
	wire hsc_auto = (|i_cart_info.save) || i_cart_info.xm[0];
	wire hsc_d = ~use_sk && ((i_status.hscart == 2'd0) ? hsc_auto : i_status.hscart[0]);
	wire pal_d = (i_status.region == 2'd0)
		? (i_tia_en ? i_tia_pal : i_cart_info.region[0])
		: i_status.region[1];

	always_ff @(posedge clk_sys or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_porta_type <= PT_NONE;
			o_portb_type <= PT_NONE;
			o_two_btn_a  <= 1'b0;
			o_two_btn_b  <= 1'b0;
			o_bw         <= 1'b0;
			o_diff       <= 2'b00;
			o_pal        <= 1'b0;
			o_hsc_en     <= 1'b0;
		end else begin
			o_porta_type <= porta_d;
			o_portb_type <= portb_d;
			o_two_btn_a  <= (i_cart_info.joy0_type != 8'(`JOY_TYPE_2600)) && !i_tia_en;
			o_two_btn_b  <= (i_cart_info.joy1_type != 8'(`JOY_TYPE_2600)) && !i_tia_en;
			o_bw         <= i_status.bw;
			o_diff       <= {i_status.diff_right, i_status.diff_left};
			o_pal        <= pal_d;
			o_hsc_en     <= hsc_d;
		end
	end

endmodule

`default_nettype wire

/* ports/port_mapper.sv */
/*
 * RIOT/TIA input mapper
 * Port A directions, port B console switches, fire latches, dump lines
 * and the SaveKey two-wire pins
 */
`timescale 1ns/1ps
`default_nettype none

module port_mapper import input_pkg::*; (
	input  wire port_type_e i_porta_type,
	input  wire port_type_e i_portb_type,
	input  wire             i_two_btn_a,
	input  wire             i_two_btn_b,
	input  wire             i_tia_en,
	input  wire             i_bw,
	input  wire [1:0]       i_diff,
	input  wire pad_t       i_pad1,
	input  wire pad_t       i_pad2,
	input  wire [7:0]       i_pa_out,
	input  wire [7:0]       i_pb_out,
	input  wire             i_sk_sda_in,
	output riot_in_t        o_riot,
	output logic            o_sk_scl,
	output logic            o_sk_sda
);

	wire sk_a = (i_porta_type == PT_SAVEKEY);
	wire sk_b = (i_portb_type == PT_SAVEKEY);

	always_comb begin
		// Port A, P1 high nibble, R L D U active low
		o_riot.pa[7:4] = sk_a ? {1'b1, i_sk_sda_in, 2'b11}
			: ~{i_pad1.right, i_pad1.left, i_pad1.down, i_pad1.up};
		o_riot.pa[3:0] = sk_b ? {1'b1, i_sk_sda_in, 2'b11}
			: ~{i_pad2.right, i_pad2.left, i_pad2.down, i_pad2.up};

		// Port B console switches
		o_riot.pb[7] = i_diff[1];
		o_riot.pb[6] = i_diff[0];
		o_riot.pb[5] = i_pb_out[5];
		o_riot.pb[4] = i_pb_out[4];      // P2 two button sense
		o_riot.pb[3] = i_tia_en ? ~i_bw : ~(i_pad1.pause | i_pad2.pause);
		o_riot.pb[2] = i_pb_out[2];      // P1 two button sense
		o_riot.pb[1] = ~(i_pad1.select | i_pad2.select);
		o_riot.pb[0] = ~i_pad1.start;

		// Fire latches
		if (i_tia_en) begin
			o_riot.ilatch[0] = ~i_pad1.fire_a;
			o_riot.ilatch[1] = ~i_pad2.fire_a;
		end else begin
			o_riot.ilatch[0] = (i_two_btn_a && !i_pb_out[2])
				|| !(i_pad1.fire_a || i_pad1.fire_b);
			o_riot.ilatch[1] = (i_two_btn_b && !i_pb_out[4])
				|| !(i_pad2.fire_a || i_pad2.fire_b);
		end

		// Dump lines carry the 7800 two button state
		if (i_tia_en) begin
			o_riot.idump[1:0] = {~i_pad1.fire_b, 1'b0};
			o_riot.idump[3:2] = {~i_pad2.fire_b, 1'b0};
		end else begin
			o_riot.idump[1:0] = {i_pad1.fire_a, i_pad1.fire_b};
			o_riot.idump[3:2] = {i_pad2.fire_a, i_pad2.fire_b};
		end
	end

	// SaveKey sits on port B pins 3/2 or port A pins 7/6
	assign o_sk_scl = sk_b ? i_pa_out[3] : i_pa_out[7];
	assign o_sk_sda = sk_b ? i_pa_out[2] : i_pa_out[6];

endmodule

`default_nettype wire

/* rtl/backup_sequencer.sv */
/*
 * Backup RAM sequencer
 * Loads on image mount and saves on request, one SD sector at a time
 */
`timescale 1ns/1ps
`default_nettype none
`include "a7800_consts.svh"

module backup_sequencer (
	input  wire        clk_sys,
	input  wire        i_arst_n,
	input  wire        i_img_mounted,
	input  wire        i_img_size_nz,
	input  wire        i_bk_save,
	input  wire        i_sd_ack,
	output logic       o_sd_rd,
	output logic       o_sd_wr,
	output logic [5:0] o_sd_lba,
	output logic       o_bk_busy,
	output logic       o_bk_ena
);

	localparam logic [5:0] LAST_SECTOR = 6'(`BK_SECTORS - 1);

	logic bk_load;
	logic old_mounted, old_load, old_save, old_ack;

	wire load_rise = bk_load & ~old_load;
	wire save_rise = i_bk_save & ~old_save;
	wire ack_rise  = i_sd_ack & ~old_ack;
	wire ack_fall  = ~i_sd_ack & old_ack;

	always_ff @(posedge clk_sys or negedge i_arst_n) begin
		if (!i_arst_n) begin
			old_mounted <= 1'b0;
			old_load    <= 1'b0;
			old_save    <= 1'b0;
			old_ack     <= 1'b0;
			bk_load     <= 1'b0;
			o_bk_ena    <= 1'b0;
			o_bk_busy   <= 1'b0;
			o_sd_rd     <= 1'b0;
			o_sd_wr     <= 1'b0;
			o_sd_lba    <= '0;
		end else begin
			old_mounted <= i_img_mounted;
			old_load    <= bk_load;
			old_save    <= i_bk_save;
			old_ack     <= i_sd_ack;

			// New image, load it back if it has content
			if (i_img_mounted && !old_mounted) begin
				o_bk_ena <= i_img_size_nz;
				bk_load  <= i_img_size_nz;
			end

			if (ack_rise) begin
				o_sd_rd <= 1'b0;
				o_sd_wr <= 1'b0;
			end

			if (!o_bk_busy) begin
				if (o_bk_ena && (load_rise || save_rise)) begin
					o_bk_busy <= 1'b1;
					o_sd_lba  <= '0;
					o_sd_rd   <= bk_load;
					o_sd_wr   <= ~bk_load;
				end
			end else if (ack_fall) begin
				if (o_sd_lba == LAST_SECTOR) begin
					bk_load   <= 1'b0;          // Done
					o_bk_busy <= 1'b0;
				end else begin
					o_sd_lba <= o_sd_lba + 6'd1;
					o_sd_rd  <= bk_load;
					o_sd_wr  <= ~bk_load;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* rtl/a7800_io_top.sv */
/*
 * Atari 7800 host glue
 * Download decode, console options, RIOT/TIA input mapping and
 * backup RAM sector sequencing
 */
`timescale 1ns/1ps
`default_nettype none
`include "a7800_consts.svh"

module a7800_io_top import cart_pkg::*, input_pkg::*; (
	input  wire                    clk_sys,
	input  wire                    i_arst_n,
	// Host download
	input  wire                    i_ioctl_download,
	input  wire                    i_ioctl_wr,
	input  wire [7:0]              i_ioctl_index,
	input  wire [`CART_ADDR_W-1:0] i_ioctl_addr,
	input  wire [7:0]              i_ioctl_dout,
	// Options and players
	input  wire options_t          i_status,
	input  wire pad_t              i_pad1,
	input  wire pad_t              i_pad2,
	input  wire                    i_tia_en,
	input  wire [7:0]              i_pa_out,
	input  wire [7:0]              i_pb_out,
	input  wire                    i_sk_sda_in,
	// SD image
	input  wire                    i_img_mounted,
	input  wire                    i_img_size_nz,
	input  wire                    i_sd_ack,

	output wire dl_kind_e          o_dl_kind,
	output wire cart_info_t        o_cart_info,
	output wire [31:0]             o_cart_size,
	output wire                    o_cart_wr,
	output wire mem_wr_t           o_cart_wdata,
	output wire riot_in_t          o_riot,
	output wire                    o_sk_scl,
	output wire                    o_sk_sda,
	output wire                    o_pal,
	output wire                    o_hsc_en,
	output wire                    o_sd_rd,
	output wire                    o_sd_wr,
	output wire [5:0]              o_sd_lba,
	output wire                    o_bk_busy,
	output wire                    o_bk_ena
);

	port_type_e porta_type;
	port_type_e portb_type;
	wire        two_btn_a;
	wire        two_btn_b;
	wire        bw;
	wire [1:0]  diff;

	cart_header_parser cart_header_parser_i (
		.clk_sys          (clk_sys),
		.i_arst_n         (i_arst_n),
		.i_ioctl_download (i_ioctl_download),
		.i_ioctl_wr       (i_ioctl_wr),
		.i_ioctl_index    (i_ioctl_index),
		.i_ioctl_addr     (i_ioctl_addr),
		.i_ioctl_dout     (i_ioctl_dout),
		.o_dl_kind        (o_dl_kind),
		.o_cart_info      (o_cart_info),
		.o_cart_size      (o_cart_size),
		.o_cart_wr        (o_cart_wr),
		.o_cart_wdata     (o_cart_wdata)
	);

	// TIA PAL detect belongs to the chipset, so auto region in TIA mode is NTSC
	console_options console_options_i (
		.clk_sys      (clk_sys),
		.i_arst_n     (i_arst_n),
		.i_status     (i_status),
		.i_cart_info  (o_cart_info),
		.i_tia_en     (i_tia_en),
		.i_tia_pal    (1'b0),
		.o_porta_type (porta_type),
		.o_portb_type (portb_type),
		.o_two_btn_a  (two_btn_a),
		.o_two_btn_b  (two_btn_b),
		.o_bw         (bw),
		.o_diff       (diff),
		.o_pal        (o_pal),
		.o_hsc_en     (o_hsc_en)
	);

	port_mapper port_mapper_i (
		.i_porta_type (porta_type),
		.i_portb_type (portb_type),
		.i_two_btn_a  (two_btn_a),
		.i_two_btn_b  (two_btn_b),
		.i_tia_en     (i_tia_en),
		.i_bw         (bw),
		.i_diff       (diff),
		.i_pad1       (i_pad1),
		.i_pad2       (i_pad2),
		.i_pa_out     (i_pa_out),
		.i_pb_out     (i_pb_out),
		.i_sk_sda_in  (i_sk_sda_in),
		.o_riot       (o_riot),
		.o_sk_scl     (o_sk_scl),
		.o_sk_sda     (o_sk_sda)
	);

	backup_sequencer backup_sequencer_i (
		.clk_sys       (clk_sys),
		.i_arst_n      (i_arst_n),
		.i_img_mounted (i_img_mounted),
		.i_img_size_nz (i_img_size_nz),
		.i_bk_save     (i_status.bk_save),
		.i_sd_ack      (i_sd_ack),
		.o_sd_rd       (o_sd_rd),
		.o_sd_wr       (o_sd_wr),
		.o_sd_lba      (o_sd_lba),
		.o_bk_busy     (o_bk_busy),
		.o_bk_ena      (o_bk_ena)
	);

endmodule

`default_nettype wire

/* test/a7800_io_asserts.sv */
/*
 * Bound checks on the 7800 host glue outputs
 * SD request exclusivity, cart write qualification and LBA stability
 */
`timescale 1ns/1ps
`default_nettype none

module a7800_io_asserts import cart_pkg::*; (
	input wire           clk_sys,
	input wire           i_arst_n,
	input wire dl_kind_e i_dl_kind,
	input wire           i_cart_wr,
	input wire           i_sd_rd,
	input wire           i_sd_wr,
	input wire [5:0]     i_sd_lba
);

	logic excl_err = 1'b0;
	logic cart_err = 1'b0;
	logic lba_err  = 1'b0;
	wire  any_err  = excl_err | cart_err | lba_err;
	wire  sd_req   = i_sd_rd | i_sd_wr;

	sd_excl: assert property (@(posedge clk_sys) disable iff (!i_arst_n)
		!(i_sd_rd && i_sd_wr))
		else begin
			excl_err = 1'b1;
			$error("SD read and write requested together");
		end

	// Cart writes only come out of a cartridge download
	cart_kind: assert property (@(posedge clk_sys) disable iff (!i_arst_n)
		i_cart_wr |-> (i_dl_kind == DL_CART))
		else begin
			cart_err = 1'b1;
			$error("Cart write outside a cartridge download");
		end

	lba_hold: assert property (@(posedge clk_sys) disable iff (!i_arst_n)
		(sd_req && $past(sd_req)) |-> $stable(i_sd_lba))
		else begin
			lba_err = 1'b1;
			$error("SD sector address moved during a request");
		end

endmodule

bind a7800_io_top a7800_io_asserts a7800_io_asserts_i (
	.clk_sys   (clk_sys),
	.i_arst_n  (i_arst_n),
	.i_dl_kind (o_dl_kind),
	.i_cart_wr (o_cart_wr),
	.i_sd_rd   (o_sd_rd),
	.i_sd_wr   (o_sd_wr),
	.i_sd_lba  (o_sd_lba)
);

`default_nettype wire

/* test/tb_a7800_io.sv */
/*
 * Testbench for the Atari 7800 host glue
 * Directed download, port mapping, region and backup RAM tests
 */
`timescale 1ns/1ps
`default_nettype none
`include "a7800_consts.svh"

module tb_a7800_io import cart_pkg::*, input_pkg::*; ();

	localparam int TIMEOUT_CYCLES = 20000;   // All tests need about 5000

	logic                    clk_sys;
	logic                    i_arst_n;
	logic                    i_ioctl_download;
	logic                    i_ioctl_wr;
	logic [7:0]              i_ioctl_index;
	logic [`CART_ADDR_W-1:0] i_ioctl_addr;
	logic [7:0]              i_ioctl_dout;
	options_t                i_status;
	pad_t                    i_pad1;
	pad_t                    i_pad2;
	logic                    i_tia_en;
	logic [7:0]              i_pa_out;
	logic [7:0]              i_pb_out;
	logic                    i_sk_sda_in;
	logic                    i_img_mounted;
	logic                    i_img_size_nz;
	logic                    i_sd_ack;
	dl_kind_e                o_dl_kind;
	cart_info_t              o_cart_info;
	logic [31:0]             o_cart_size;
	logic                    o_cart_wr;
	mem_wr_t                 o_cart_wdata;
	riot_in_t                o_riot;
	logic                    o_sk_scl;
	logic                    o_sk_sda;
	logic                    o_pal;
	logic                    o_hsc_en;
	logic                    o_sd_rd;
	logic                    o_sd_wr;
	logic [5:0]              o_sd_lba;
	logic                    o_bk_busy;
	logic                    o_bk_ena;

	logic [7:0]  img [0:255];   // Download image
	cart_info_t  exp_info;      // Header as the last download should leave it
	logic [31:0] exp_size;
	int          cycles = 0;

	// SD request rises seen on the outputs
	logic sd_rd_q = 1'b0;
	logic sd_wr_q = 1'b0;
	int   rd_reqs = 0;
	int   wr_reqs = 0;

	a7800_io_top a7800_io_top_i (.*);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, a test is stuck waiting", cycles);
			$display("Simulation failed");
			$fatal(1, "timeout");
		end
	end

	always @(posedge clk_sys) begin
		sd_rd_q <= o_sd_rd;
		sd_wr_q <= o_sd_wr;
		if (o_sd_rd && !sd_rd_q)
			rd_reqs <= rd_reqs + 1;
		if (o_sd_wr && !sd_wr_q)
			wr_reqs <= wr_reqs + 1;
	end

	// ==================================================================
	// Helpers
	// ==================================================================
	task automatic next_cycle();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic expect_eq(input string test, input logic [63:0] exp, input logic [63:0] act);
		assert (act === exp) else begin
			$display("MISMATCH %s expected %0h actual %0h", test, exp, act);
			$display("Simulation failed");
			$fatal(1, "value check did not match");
		end
	endtask

	// Header joystick table with the OSD override on top
	function automatic port_type_e port_for(input logic [1:0] ovr, input logic [7:0] code);
		port_type_e pt;
		if (ovr == 2'd3) begin
			pt = PT_SAVEKEY;
		end else if (ovr != 2'd0) begin
			pt = PT_JOY7800;     // Paddle override ends up as joystick
		end else begin
			case (code)
				8'd0:    pt = PT_NONE;
				8'd2:    pt = PT_LIGHTGUN;
				8'd4:    pt = PT_TRAKBALL;
				8'd6:    pt = PT_DRIVING;
				8'd7:    pt = PT_JOY2600;
				8'd8:    pt = PT_STMOUSE;
				8'd9:    pt = PT_AMIGAMOUSE;
				8'd10:   pt = PT_SAVEKEY;
				default: pt = PT_JOY7800;
			endcase
		end
		return pt;
	endfunction

	task automatic build_image(input logic atari);
		logic [31:0] r;
		for (int a = 0; a < 256; a++) begin
			r = $urandom;
			img[a] = r[7:0];
		end
		if (atari) begin
			img[1] = "A";
			img[2] = "T";
			img[3] = "A";
			img[4] = "R";
			img[5] = "I";
		end
	endtask

	// Sends img[0..count-1], checks every cart write and then the header
	task automatic download(input string test, input logic [7:0] index, input int count);
		logic                    tia;
		logic                    hdr;
		logic [`CART_ADDR_W-1:0] exp_addr;
		tia = |index[7:6];
		hdr = !tia && ({img[1], img[2], img[3], img[4], img[5]} == "ATARI");
		i_ioctl_index    = index;
		i_ioctl_download = 1'b1;
		next_cycle();
		for (int a = 0; a < count; a++) begin
			i_ioctl_addr = `CART_ADDR_W'(a);
			i_ioctl_dout = img[a];
			i_ioctl_wr   = 1'b1;
			next_cycle();
			i_ioctl_wr = 1'b0;
			exp_addr = (hdr && a >= `A78_HDR_BYTES) ? `CART_ADDR_W'(a - `A78_HDR_BYTES)
				: `CART_ADDR_W'(a);
			expect_eq({test, " wr"}, 64'(1), 64'(o_cart_wr));
			expect_eq({test, " addr"}, 64'(exp_addr), 64'(o_cart_wdata.addr));
			expect_eq({test, " data"}, 64'(img[a]), 64'(o_cart_wdata.data));
			next_cycle();
		end
		i_ioctl_download = 1'b0;
		exp_info.is_7800   = hdr;
		exp_info.flags     = hdr ? {img[`A78_OFS_FLAGS_HI], img[`A78_OFS_FLAGS_LO]} : 16'd0;
		exp_info.joy0_type = hdr ? img[`A78_OFS_JOY0] : 8'd1;
		exp_info.joy1_type = hdr ? img[`A78_OFS_JOY1] : 8'd1;
		exp_info.region    = tia ? 8'd0 : img[`A78_OFS_REGION];
		exp_info.save      = tia ? 8'd0 : img[`A78_OFS_SAVE];
		exp_info.xm        = hdr ? img[`A78_OFS_XM] : 8'd0;
		exp_size = hdr ? 32'(count - `A78_HDR_BYTES) : 32'(count);
		next_cycle();
		expect_eq({test, " info"}, 64'(exp_info), 64'(o_cart_info));
		expect_eq({test, " size"}, 64'(exp_size), 64'(o_cart_size));
	endtask

	// Answers each SD request with an ack pulse
	task automatic serve_sectors(input string test, input logic rd);
		int start_cnt;
		start_cnt = rd ? rd_reqs : wr_reqs;
		for (int s = 0; s < `BK_SECTORS; s++) begin
			while (!(rd ? o_sd_rd : o_sd_wr))
				next_cycle();
			expect_eq({test, " lba"}, 64'(s), 64'(o_sd_lba));
			expect_eq({test, " other request"}, 64'(0), 64'(rd ? o_sd_wr : o_sd_rd));
			i_sd_ack = 1'b1;
			next_cycle();
			expect_eq({test, " request drop"}, 64'(0), 64'(o_sd_rd | o_sd_wr));
			next_cycle();
			i_sd_ack = 1'b0;
		end
		while (o_bk_busy)
			next_cycle();
		expect_eq({test, " count"}, 64'(`BK_SECTORS),
			64'((rd ? rd_reqs : wr_reqs) - start_cnt));
		expect_eq({test, " idle"}, 64'(0), 64'({o_sd_rd, o_sd_wr}));
	endtask

	// ==================================================================
	// Tests
	// ==================================================================
	task automatic test_dl_kind();
		dl_kind_e exp_kind;
		for (int idx = 0; idx < 8; idx++) begin
			case (idx)
				0, 2:    exp_kind = DL_BIOS;
				1:       exp_kind = DL_CART;
				3:       exp_kind = DL_PALETTE;
				default: exp_kind = DL_NONE;
			endcase
			i_ioctl_index    = 8'(idx);
			i_ioctl_download = 1'b1;
			next_cycle();
			expect_eq("download kind", 64'(exp_kind), 64'(o_dl_kind));
			i_ioctl_download = 1'b0;
			next_cycle();
			expect_eq("download kind idle", 64'(DL_NONE), 64'(o_dl_kind));
		end
	endtask

	task automatic test_7800_download();
		build_image(1'b1);
		download("7800 download", 8'h01, 256);
	endtask

	task automatic test_tia_download();
		build_image(1'b1);      // Signature is ignored in TIA mode
		download("tia download", 8'h41, 200);
	endtask

	task automatic test_port_resolution();
		logic [31:0] r;
		port_type_e  exp_a;
		port_type_e  exp_b;
		logic [3:0]  nib_a;
		logic [3:0]  nib_b;
		for (int code = 0; code < 12; code++) begin
			build_image(1'b1);
			img[`A78_OFS_JOY0] = 8'(code);
			download("port header", 8'h01, 64);
			for (int ovr = 0; ovr < 16; ovr++) begin
				i_status.ctrl1 = 2'(ovr >> 2);
				i_status.ctrl2 = 2'(ovr);
				next_cycle();
				r = $urandom;
				i_pad1      = r[8:0];
				i_pad2      = r[17:9];
				i_sk_sda_in = r[18];
				i_pa_out    = r[26:19];
				#1;
				exp_a = port_for(i_status.ctrl1, exp_info.joy0_type);   // Both ports read joy0
				exp_b = port_for(i_status.ctrl2, exp_info.joy0_type);
				nib_a = (exp_a == PT_SAVEKEY) ? {1'b1, i_sk_sda_in, 2'b11}
					: ~{i_pad1.right, i_pad1.left, i_pad1.down, i_pad1.up};
				nib_b = (exp_b == PT_SAVEKEY) ? {1'b1, i_sk_sda_in, 2'b11}
					: ~{i_pad2.right, i_pad2.left, i_pad2.down, i_pad2.up};
				expect_eq("port a", 64'({nib_a, nib_b}), 64'(o_riot.pa));
				expect_eq("savekey pins",
					64'((exp_b == PT_SAVEKEY) ? i_pa_out[3:2] : i_pa_out[7:6]),
					64'({o_sk_scl, o_sk_sda}));
			end
		end
	endtask

	task automatic test_port_b();
		logic [31:0] r;
		logic        two_a;
		logic        two_b;
		logic [7:0]  exp_pb;
		logic [1:0]  exp_latch;
		logic [3:0]  exp_dump;
		build_image(1'b1);
		img[`A78_OFS_JOY0] = 8'(`JOY_TYPE_2600);   // P1 single button, P2 two button
		img[`A78_OFS_JOY1] = 8'd1;
		download("port b header", 8'h01, 64);
		for (int n = 0; n < 200; n++) begin
			r = $urandom;
			i_pad1              = r[8:0];
			i_pad2              = r[17:9];
			i_pb_out            = r[25:18];
			i_tia_en            = r[26];
			i_status.bw         = r[27];
			i_status.diff_left  = r[28];
			i_status.diff_right = r[29];
			next_cycle();
			two_a = (exp_info.joy0_type != 8'(`JOY_TYPE_2600)) && !i_tia_en;
			two_b = (exp_info.joy1_type != 8'(`JOY_TYPE_2600)) && !i_tia_en;
			exp_pb = {i_status.diff_right, i_status.diff_left, i_pb_out[5], i_pb_out[4],
				i_tia_en ? ~i_status.bw : ~(i_pad1.pause | i_pad2.pause), i_pb_out[2],
				~(i_pad1.select | i_pad2.select), ~i_pad1.start};
			if (i_tia_en) begin
				exp_latch = ~{i_pad2.fire_a, i_pad1.fire_a};
				exp_dump  = {~i_pad2.fire_b, 1'b0, ~i_pad1.fire_b, 1'b0};
			end else begin
				exp_latch[0] = (two_a && !i_pb_out[2]) || !(i_pad1.fire_a || i_pad1.fire_b);
				exp_latch[1] = (two_b && !i_pb_out[4]) || !(i_pad2.fire_a || i_pad2.fire_b);
				exp_dump     = {i_pad2.fire_a, i_pad2.fire_b, i_pad1.fire_a, i_pad1.fire_b};
			end
			expect_eq("port b", 64'(exp_pb), 64'(o_riot.pb));
			expect_eq("fire latch", 64'(exp_latch), 64'(o_riot.ilatch));
			expect_eq("dump lines", 64'(exp_dump), 64'(o_riot.idump));
		end
	endtask

	task automatic test_backup();
		i_img_size_nz = 1'b1;
		i_img_mounted = 1'b1;
		next_cycle();
		i_img_mounted = 1'b0;
		expect_eq("backup enable", 64'(1), 64'(o_bk_ena));
		serve_sectors("backup load", 1'b1);
		i_status.bk_save = 1'b1;
		serve_sectors("backup save", 1'b0);
		i_status.bk_save = 1'b0;
	endtask

	task automatic test_region_hsc();
		logic [31:0] r;
		port_type_e  exp_a;
		port_type_e  exp_b;
		logic        exp_pal;
		logic        exp_hsc;
		for (int h = 0; h < 3; h++) begin
			build_image(1'b1);
			img[`A78_OFS_JOY0] = 8'($urandom_range(11, 0));
			if (h < 2)
				img[`A78_OFS_SAVE] = 8'd0;
			if (h == 0)
				img[`A78_OFS_XM] = 8'd0;
			download("region header", 8'h01, 64);
			for (int n = 0; n < 40; n++) begin
				r = $urandom;
				i_status.region = r[1:0];
				i_status.hscart = r[3:2];
				i_status.ctrl1  = r[5:4];
				i_status.ctrl2  = r[7:6];
				i_tia_en        = r[8];
				next_cycle();
				exp_a = port_for(i_status.ctrl1, exp_info.joy0_type);
				exp_b = port_for(i_status.ctrl2, exp_info.joy0_type);
				if (i_status.region == 2'd0)
					exp_pal = i_tia_en ? 1'b0 : exp_info.region[0];   // No TIA PAL detect here
				else
					exp_pal = i_status.region[1];
				if (exp_a == PT_SAVEKEY || exp_b == PT_SAVEKEY)
					exp_hsc = 1'b0;
				else if (i_status.hscart == 2'd0)
					exp_hsc = (exp_info.save != 8'd0) || exp_info.xm[0];
				else
					exp_hsc = i_status.hscart[0];
				expect_eq("region", 64'(exp_pal), 64'(o_pal));
				expect_eq("high score enable", 64'(exp_hsc), 64'(o_hsc_en));
			end
		end
	endtask

	// ==================================================================
	// Main sequence
	// ==================================================================
	initial begin
		void'($urandom(65606));
		i_arst_n         = 1'b0;
		i_ioctl_download = 1'b0;
		i_ioctl_wr       = 1'b0;
		i_ioctl_index    = '0;
		i_ioctl_addr     = '0;
		i_ioctl_dout     = '0;
		i_status         = '0;
		i_pad1           = '0;
		i_pad2           = '0;
		i_tia_en         = 1'b0;
		i_pa_out         = '0;
		i_pb_out         = '0;
		i_sk_sda_in      = 1'b0;
		i_img_mounted    = 1'b0;
		i_img_size_nz    = 1'b0;
		i_sd_ack         = 1'b0;
		repeat (2) @(posedge clk_sys);
		#1;
		i_arst_n = 1'b1;
		expect_eq("reset", 64'(0), 64'({o_cart_wr, o_sd_rd, o_sd_wr, o_bk_busy}));

		test_dl_kind();
		test_7800_download();
		test_tia_download();
		test_port_resolution();
		test_port_b();
		test_backup();
		test_region_hsc();
		next_cycle();

		if (!a7800_io_top_i.a7800_io_asserts_i.any_err) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* a7800_io_top.f */
+incdir+common
common/cart_pkg.sv
common/input_pkg.sv
cart/cart_header_parser.sv
ports/console_options.sv
ports/port_mapper.sv
rtl/backup_sequencer.sv
rtl/a7800_io_top.sv
test/a7800_io_asserts.sv
test/tb_a7800_io.sv

/* Makefile */
# Verilator simulation of the 7800 host glue
TOP = tb_a7800_io

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f a7800_io_top.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Simulation passed"

clean:
	rm -rf obj_dir

.PHONY: sim clean
